/* compile.f */
hdl/cart_pkg.sv
hdl/cart_id_pkg.sv
hdl/rom_loader.sv
hdl/header_detect.sv
hdl/cart_rom.sv
hdl/md_mapper.sv
hdl/save_ram.sv
hdl/cart_bus.sv
hdl/cart_top.sv
tb/tb_cart.sv

/* hdl/cart_bus.sv */
//==========================================================================
// Cartridge bus read side
//   Source select aligned to the memory latency
//   Read data register and data enable
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module cart_bus (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          cart_cs,
	input  wire                          cart_oe,
	input  wire                          sram_cs,
	input  wire  [cart_pkg::DATA_W-1:0]  rom_q,
	input  wire  [7:0]                   sram_q,
	output logic [cart_pkg::DATA_W-1:0]  cart_data,
	output logic                         cart_data_en
);

	logic sram_sel;

	// Select follows the address into the RAM read stage
	always_ff @(posedge clk) begin
		if (reset) begin
			sram_sel     <= 1'b0;
			cart_data_en <= 1'b0;
		end else begin
			sram_sel     <= sram_cs;
			cart_data_en <= cart_oe & (cart_cs | sram_cs);
		end
	end

	// Save RAM byte shows on both lanes
	always_ff @(posedge clk) begin
		cart_data <= sram_sel ? {sram_q, sram_q} : rom_q;
	end

endmodule

`default_nettype wire

/* hdl/cart_id_pkg.sv */
//==========================================================================
// Cartridge identification
//   Quirk encoding returned by the header detector
//   ROM header offsets of the game serial
//   Serial strings that select a quirk
//==========================================================================

`default_nettype none

package cart_id_pkg;

	typedef enum logic [1:0] {
		quirk_none   = 2'd0,
		quirk_noram  = 2'd1,
		quirk_sram00 = 2'd2
	} quirk_e;

	// First byte of the 8 character serial in the header
	localparam int SERIAL_OFFSET = 'h183;

	// Download byte address at which the serial is complete
	localparam int HEADER_END = 'h190;

	// Game that probes for save RAM and must not find any
	localparam logic [63:0] NORAM_SERIAL = "T-113016";

	// Game that expects save RAM cleared to zero
	localparam logic [63:0] SRAM00_SERIAL = " GM 0000";

endpackage

`default_nettype wire

/* hdl/cart_pkg.sv */
//==========================================================================
// Cartridge slot shared constants
//   CPU, data and download bus widths
//   Address map of the save RAM region
//   Bank register count and reset values
//==========================================================================

`default_nettype none

package cart_pkg;

	// Bus widths
	localparam int CPU_AW = 23;
	localparam int DATA_W = 16;
	localparam int DL_AW  = 25;

	// cart_addr[23:21] value of the save RAM window
	localparam logic [2:0] SRAM_REGION = 3'd1;

	// Save RAM size in bytes, as an address width
	localparam int SAVE_AW = 15;

	// SSF2 page registers, linear mapping out of reset
	localparam int BANK_COUNT = 8;
	localparam int BANK_INIT [BANK_COUNT] = '{0, 1, 2, 3, 4, 5, 6, 7};

endpackage

`default_nettype wire

/* hdl/cart_rom.sv */
//==========================================================================
// Cartridge ROM
//   Block RAM of 2^ROM_AW words
//   Download write port and registered CPU read port
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module cart_rom #(
	parameter int ROM_AW = 22
) (
	input  wire                          clk,
	input  wire                          rom_wr_en,
	input  wire  [ROM_AW-1:0]            rom_wr_addr,
	input  wire  [cart_pkg::DATA_W-1:0]  rom_wr_data,
	input  wire  [ROM_AW-1:0]            rom_rd_addr,
	output logic [cart_pkg::DATA_W-1:0]  rom_q
);

	logic [cart_pkg::DATA_W-1:0] mem [2**ROM_AW];

	always_ff @(posedge clk) begin
		if (rom_wr_en)
			mem[rom_wr_addr] <= rom_wr_data;
	end

	// Data one clock after the address
	always_ff @(posedge clk) begin
		rom_q <= mem[rom_rd_addr];
	end

endmodule

`default_nettype wire

/* hdl/cart_top.sv */
//==========================================================================
// Mega Drive cartridge slot top level
//   ROM loader and header detector on the download stream
//   Mapper, ROM, save RAM and bus read side for the CPU
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module cart_top #(
	parameter int ROM_AW  = 22,
	parameter int PAGE_AW = 18
) (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             cart_dl,
	input  wire                             cart_dl_wr,
	input  wire  [cart_pkg::DL_AW-1:0]      cart_dl_addr,
	input  wire  [cart_pkg::DATA_W-1:0]     cart_dl_data,
	input  wire  [cart_pkg::CPU_AW:1]       cart_addr,
	input  wire                             cart_cs,
	input  wire                             cart_oe,
	input  wire                             cart_lwr,
	input  wire                             cart_uwr,
	input  wire                             cart_time,
	input  wire  [cart_pkg::DATA_W-1:0]     cart_data_wr,
	input  wire  [cart_pkg::SAVE_AW-2:0]    save_addr,
	input  wire  [cart_pkg::DATA_W-1:0]     save_di,
	input  wire                             save_wr,
	output logic [cart_pkg::DATA_W-1:0]     cart_data,
	output logic                            cart_data_en,
	output logic [cart_pkg::DATA_W-1:0]     save_do,
	output logic                            save_change
);

	logic                        rom_wr_en;
	logic [ROM_AW-1:0]           rom_wr_addr;
	logic [cart_pkg::DATA_W-1:0] rom_wr_data;
	logic [cart_pkg::DL_AW-1:0]  rom_size;
	logic [ROM_AW-1:0]           rom_mask;
	logic [ROM_AW-1:0]           rom_rd_addr;
	logic [cart_pkg::DATA_W-1:0] rom_q;
	logic [7:0]                  sram_q;
	logic                        sram_cs;
	logic                        cart_rd;
	cart_id_pkg::quirk_e         cart_quirk;

	// A cycle with either write strobe is not a read
	assign cart_rd = cart_oe & ~(cart_lwr | cart_uwr);

	//==========================================================================
	// Download side
	//==========================================================================
	rom_loader #(.ROM_AW(ROM_AW)) loader_i (
		.clk(clk), .reset(reset), .cart_dl(cart_dl), .cart_dl_wr(cart_dl_wr),
		.cart_dl_data(cart_dl_data), .rom_wr_en(rom_wr_en), .rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data), .rom_size(rom_size), .rom_mask(rom_mask)
	);

	header_detect detect_i (
		.clk(clk), .reset(reset), .cart_dl(cart_dl), .cart_dl_wr(cart_dl_wr),
		.cart_dl_addr(cart_dl_addr), .cart_dl_data(cart_dl_data), .cart_quirk(cart_quirk)
	);

	//==========================================================================
	// CPU side
	//==========================================================================
	md_mapper #(.ROM_AW(ROM_AW), .PAGE_AW(PAGE_AW)) mapper_i (
		.clk(clk), .reset(reset), .cart_addr(cart_addr), .cart_lwr(cart_lwr),
		.cart_time(cart_time), .cart_data_wr(cart_data_wr), .rom_size(rom_size),
		.rom_mask(rom_mask), .cart_quirk(cart_quirk), .rom_rd_addr(rom_rd_addr),
		.sram_cs(sram_cs)
	);

	cart_rom #(.ROM_AW(ROM_AW)) rom_i (
		.clk(clk), .rom_wr_en(rom_wr_en), .rom_wr_addr(rom_wr_addr),
		.rom_wr_data(rom_wr_data), .rom_rd_addr(rom_rd_addr), .rom_q(rom_q)
	);

	save_ram sram_i (
		.clk(clk), .cart_dl(cart_dl), .cart_quirk(cart_quirk), .sram_cs(sram_cs),
		.cart_lwr(cart_lwr), .cart_addr(cart_addr[cart_pkg::SAVE_AW:1]),
		.cart_data_wr(cart_data_wr[7:0]), .save_addr(save_addr), .save_di(save_di),
		.save_wr(save_wr), .sram_q(sram_q), .save_do(save_do), .save_change(save_change)
	);

	cart_bus bus_i (
		.clk(clk), .reset(reset), .cart_cs(cart_cs), .cart_oe(cart_rd), .sram_cs(sram_cs),
		.rom_q(rom_q), .sram_q(sram_q), .cart_data(cart_data), .cart_data_en(cart_data_en)
	);

endmodule

`default_nettype wire

/* hdl/header_detect.sv */
//==========================================================================
// ROM header quirk detector
//   Captures the game serial from the download stream
//   Matches it against the known serials at the end of the header
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module header_detect (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           cart_dl,
	input  wire                           cart_dl_wr,
	input  wire   [cart_pkg::DL_AW-1:0]   cart_dl_addr,
	input  wire   [cart_pkg::DATA_W-1:0]  cart_dl_data,
	output cart_id_pkg::quirk_e           cart_quirk
);

	localparam int AW  = cart_pkg::DL_AW;
	localparam int SER = cart_id_pkg::SERIAL_OFFSET;

	// Header words that carry the serial, odd start so the first is split
	localparam logic [AW-1:0] SER_W0  = AW'(SER - 1);
	localparam logic [AW-1:0] SER_W1  = AW'(SER + 1);
	localparam logic [AW-1:0] SER_W2  = AW'(SER + 3);
	localparam logic [AW-1:0] SER_W3  = AW'(SER + 5);
	localparam logic [AW-1:0] SER_W4  = AW'(SER + 7);
	localparam logic [AW-1:0] HDR_END = AW'(cart_id_pkg::HEADER_END);

	logic        dl_q;
	logic        dl_wr;
	logic [15:0] swapped;
	logic [63:0] serial;

	assign dl_wr = cart_dl & cart_dl_wr;

	// Download words arrive with the even byte in the low half
	assign swapped = {cart_dl_data[7:0], cart_dl_data[15:8]};

	always_ff @(posedge clk) begin
		if (reset)
			dl_q <= 1'b0;
		else
			dl_q <= cart_dl;
	end

	always_ff @(posedge clk) begin
		if (dl_wr) begin
			case (cart_dl_addr)
				SER_W0:  serial[63:56] <= swapped[7:0];
				SER_W1:  serial[55:40] <= swapped;
				SER_W2:  serial[39:24] <= swapped;
				SER_W3:  serial[23:8]  <= swapped;
				SER_W4:  serial[7:0]   <= swapped[15:8];
				default: serial        <= serial;
			endcase
		end
	end

	// Quirk is a property of the loaded image, kept across CPU reset
	always_ff @(posedge clk) begin
		if (cart_dl & ~dl_q) begin
			cart_quirk <= cart_id_pkg::quirk_none;
		end else if (dl_wr && cart_dl_addr == HDR_END) begin
			if (serial == cart_id_pkg::NORAM_SERIAL)
				cart_quirk <= cart_id_pkg::quirk_noram;
			else if (serial == cart_id_pkg::SRAM00_SERIAL)
				cart_quirk <= cart_id_pkg::quirk_sram00;
		end
	end

endmodule

`default_nettype wire

/* hdl/md_mapper.sv */
//==========================================================================
// Mega Drive cartridge mapper
//   SSF2 page registers and save RAM enable bit
//   ROM address translation and save RAM select
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module md_mapper #(
	parameter int ROM_AW  = 22,
	parameter int PAGE_AW = 18
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire   [cart_pkg::CPU_AW:1]    cart_addr,
	input  wire                           cart_lwr,
	input  wire                           cart_time,
	input  wire   [cart_pkg::DATA_W-1:0]  cart_data_wr,
	input  wire   [cart_pkg::DL_AW-1:0]   rom_size,
	input  wire   [ROM_AW-1:0]            rom_mask,
	input  wire   cart_id_pkg::quirk_e    cart_quirk,
	output logic  [ROM_AW-1:0]            rom_rd_addr,
	output logic                          sram_cs
);

	localparam int BANK_W = ROM_AW - PAGE_AW;

	logic [BANK_W-1:0]           bank [cart_pkg::BANK_COUNT];
	logic                        bank_use;
	logic                        bank_sram;
	logic [cart_pkg::CPU_AW-1:0] word_addr;
	logic [2:0]                  page;
	logic                        big_rom;

	// Zero based word address, bit 0 is cart_addr[1]
	assign word_addr = cart_addr;
	assign page      = word_addr[PAGE_AW+2:PAGE_AW];

	// Banking only makes sense past eight pages
	assign big_rom = |rom_mask[ROM_AW-1:PAGE_AW+3];

	//==========================================================================
	// Bank registers in the time region
	//==========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cart_pkg::BANK_COUNT; i++)
				bank[i] <= BANK_W'(cart_pkg::BANK_INIT[i]);
			bank_use  <= 1'b0;
			bank_sram <= 1'b0;
		end else if (cart_lwr && cart_time) begin
			if (cart_addr[3:1] == 3'd0) begin
				bank_sram <= cart_data_wr[0];
			end else if (big_rom) begin
				bank[cart_addr[3:1]] <= cart_data_wr[BANK_W-1:0];
				bank_use             <= 1'b1;
			end
		end
	end

	//==========================================================================
	// Address translation
	//==========================================================================
	always_comb begin
		if (bank_use)
			rom_rd_addr = {bank[page], word_addr[PAGE_AW-1:0]} & rom_mask;
		else
			rom_rd_addr = word_addr[ROM_AW-1:0] & rom_mask;
	end

	// Save RAM when enabled, or past the end of a small ROM
	assign sram_cs = (cart_addr[cart_pkg::CPU_AW:cart_pkg::CPU_AW-2] == cart_pkg::SRAM_REGION)
		&& (cart_quirk != cart_id_pkg::quirk_noram)
		&& (bank_sram || (cart_pkg::DL_AW'(word_addr) >= rom_size));

endmodule

`default_nettype wire

/* hdl/rom_loader.sv */
//==========================================================================
// ROM download loader
//   Word counter and ROM write port
//   Loaded size and power of two address mask
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module rom_loader #(
	parameter int ROM_AW = 22
) (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          cart_dl,
	input  wire                          cart_dl_wr,
	input  wire  [cart_pkg::DATA_W-1:0]  cart_dl_data,
	output logic                         rom_wr_en,
	output logic [ROM_AW-1:0]            rom_wr_addr,
	output logic [cart_pkg::DATA_W-1:0]  rom_wr_data,
	output logic [cart_pkg::DL_AW-1:0]   rom_size,
	output logic [ROM_AW-1:0]            rom_mask
);

	logic                       dl_q;
	logic                       dl_start;
	logic                       dl_wr;
	logic [cart_pkg::DL_AW-1:0] count;
	logic [ROM_AW-1:0]          mask;

	assign dl_start = cart_dl & ~dl_q;
	assign dl_wr    = cart_dl & cart_dl_wr;

	// A new download starts from an empty ROM
	assign count = dl_start ? '0 : rom_size;
	assign mask  = dl_start ? '0 : rom_mask;

	always_ff @(posedge clk) begin
		if (reset) begin
			dl_q      <= 1'b0;
			rom_wr_en <= 1'b0;
		end else begin
			dl_q      <= cart_dl;
			rom_wr_en <= dl_wr;
		end
	end

	// Size and mask belong to the loaded image and survive a CPU reset
	always_ff @(posedge clk) begin
		if (dl_wr) begin
			rom_size <= count + 1'b1;
			rom_mask <= mask | count[ROM_AW-1:0];
		end else if (dl_start) begin
			rom_size <= '0;
			rom_mask <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (dl_wr) begin
			rom_wr_addr <= count[ROM_AW-1:0];
			rom_wr_data <= cart_dl_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/save_ram.sv */
//==========================================================================
// Battery save RAM
//   Byte port for the CPU on the low data lane
//   Word port for the host save file, filled during a download
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module save_ram (
	input  wire                            clk,
	input  wire                            cart_dl,
	input  wire   cart_id_pkg::quirk_e     cart_quirk,
	input  wire                            sram_cs,
	input  wire                            cart_lwr,
	input  wire   [cart_pkg::SAVE_AW:1]    cart_addr,
	input  wire   [7:0]                    cart_data_wr,
	input  wire   [cart_pkg::SAVE_AW-2:0]  save_addr,
	input  wire   [cart_pkg::DATA_W-1:0]   save_di,
	input  wire                            save_wr,
	output logic  [7:0]                    sram_q,
	output logic  [cart_pkg::DATA_W-1:0]   save_do,
	output logic                           save_change
);

	localparam int WORD_AW = cart_pkg::SAVE_AW - 1;

	logic [7:0]                  mem_lo [2**WORD_AW];
	logic [7:0]                  mem_hi [2**WORD_AW];
	logic                        cpu_wr;
	logic                        cpu_lane;
	logic [WORD_AW-1:0]          cpu_word;
	logic [WORD_AW-1:0]          fill_addr;
	logic [WORD_AW-1:0]          b_addr;
	logic [cart_pkg::DATA_W-1:0] b_data;
	logic                        b_wr;

	// Even save bytes sit in the low half of a host word
	assign cpu_lane    = cart_addr[1];
	assign cpu_word    = cart_addr[cart_pkg::SAVE_AW:2];
	assign cpu_wr      = sram_cs & cart_lwr;
	assign save_change = cpu_wr;

	always_ff @(posedge clk) begin
		if (!cart_dl)
			fill_addr <= '0;
		else
			fill_addr <= fill_addr + 1'b1;
	end

	//==========================================================================
	// Host port, or fill while a new image loads
	//==========================================================================
	always_comb begin
		if (cart_dl) begin
			b_addr = fill_addr;
			b_data = (cart_quirk == cart_id_pkg::quirk_sram00) ? 16'h0000 : 16'hFFFF;
			b_wr   = 1'b1;
		end else begin
			b_addr = save_addr;
			b_data = save_di;
			b_wr   = save_wr;
		end
	end

	// Host write wins on a collision
	always_ff @(posedge clk) begin
		if (cpu_wr && !cpu_lane)
			mem_lo[cpu_word] <= cart_data_wr;
		if (b_wr)
			mem_lo[b_addr] <= b_data[7:0];
	end

	always_ff @(posedge clk) begin
		if (cpu_wr && cpu_lane)
			mem_hi[cpu_word] <= cart_data_wr;
		if (b_wr)
			mem_hi[b_addr] <= b_data[15:8];
	end

	always_ff @(posedge clk) begin
		sram_q  <= cpu_lane ? mem_hi[cpu_word] : mem_lo[cpu_word];
		save_do <= {mem_hi[b_addr], mem_lo[b_addr]};
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the cartridge slot testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_cart \
	-Mdir obj_dir -f compile.f > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_cart > sim.log 2>&1
cat sim.log

grep -qx "TEST PASSED" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }

/* tb/tb_cart.sv */
//==========================================================================
// Cartridge slot testbench
//   Reference ROM image, bank state and expected read word
//   Download, bank, save RAM and header quirk stimulus
//   Read comparison process with error counting
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module tb_cart;

	localparam int ROM_AW      = 8;
	localparam int PAGE_AW     = 4;
	localparam int ROM_WORDS   = 2**ROM_AW;
	localparam int FILL_CYCLES = 2**14 + 64;
	localparam int DRAIN_LIMIT = 32;
	localparam logic [31:0] SEED = 32'h77ca40db;
	localparam logic [22:0] SAVE_BASE = {cart_pkg::SRAM_REGION, 20'h0};

	logic                         clk;
	logic                         reset;
	logic                         cart_dl;
	logic                         cart_dl_wr;
	logic [cart_pkg::DL_AW-1:0]   cart_dl_addr;
	logic [cart_pkg::DATA_W-1:0]  cart_dl_data;
	logic [cart_pkg::CPU_AW:1]    cart_addr;
	logic                         cart_cs;
	logic                         cart_oe;
	logic                         cart_lwr;
	logic                         cart_uwr;
	logic                         cart_time;
	logic [cart_pkg::DATA_W-1:0]  cart_data_wr;
	logic [cart_pkg::SAVE_AW-2:0] save_addr;
	logic [cart_pkg::DATA_W-1:0]  save_di;
	logic                         save_wr;
	logic [cart_pkg::DATA_W-1:0]  cart_data;
	logic                         cart_data_en;
	logic [cart_pkg::DATA_W-1:0]  save_do;
	logic                         save_change;

	// Reference image and mapper state
	logic [15:0]       rom_ref [ROM_WORDS];
	logic [15:0]       dl_words [ROM_WORDS];
	int                size_ref;
	logic [ROM_AW-1:0] mask_ref;
	logic [3:0]        bank_ref [8];
	bit                bank_on_ref;

	int          cycle_count = 0;
	int          errors = 0;
	int          checks = 0;
	int          due_q[$];
	logic [15:0] exp_q[$];
	bit          en_q[$];
	bit          data_q[$];

	cart_top #(.ROM_AW(ROM_AW), .PAGE_AW(PAGE_AW)) dut_i (
		.clk(clk), .reset(reset), .cart_dl(cart_dl), .cart_dl_wr(cart_dl_wr),
		.cart_dl_addr(cart_dl_addr), .cart_dl_data(cart_dl_data), .cart_addr(cart_addr),
		.cart_cs(cart_cs), .cart_oe(cart_oe), .cart_lwr(cart_lwr), .cart_uwr(cart_uwr),
		.cart_time(cart_time), .cart_data_wr(cart_data_wr), .save_addr(save_addr),
		.save_di(save_di), .save_wr(save_wr), .cart_data(cart_data),
		.cart_data_en(cart_data_en), .save_do(save_do), .save_change(save_change)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Expected ROM word for a CPU word address
	function automatic logic [15:0] expected_rom_word(input logic [22:0] addr);
		logic [ROM_AW-1:0] rom_addr;
		logic [2:0]        page;
		page = addr[PAGE_AW+2:PAGE_AW];
		if (bank_on_ref)
			rom_addr = {bank_ref[page], addr[PAGE_AW-1:0]} & mask_ref;
		else
			rom_addr = addr[ROM_AW-1:0] & mask_ref;
		return rom_ref[rom_addr];
	endfunction

	//==========================================================================
	// Read comparison two edges after the address
	//==========================================================================
	always @(negedge clk) begin : compare_reads
		logic [15:0] exp_word;
		bit          exp_en;
		bit          check_data;
		if (due_q.size() > 0 && cycle_count >= due_q[0]) begin
			void'(due_q.pop_front());
			exp_word   = exp_q.pop_front();
			exp_en     = en_q.pop_front();
			check_data = data_q.pop_front();
			checks++;
			assert (cart_data_en === exp_en) else begin
				errors++;
				$display("FAIL t=%0t cart_data_en exp=%b got=%b", $time, exp_en, cart_data_en);
			end
			if (check_data) begin
				assert (cart_data === exp_word) else begin
					errors++;
					$display("FAIL t=%0t cart_data exp=%h got=%h", $time, exp_word, cart_data);
				end
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_reset();
		reset = 1'b1;
		repeat (8) next_cycle();
		reset = 1'b0;
	endtask

	// Serial bytes go to odd and even header bytes of the download words
	task automatic place_serial(input logic [63:0] serial);
		int b;
		for (int k = 0; k < 8; k++) begin
			b = cart_id_pkg::SERIAL_OFFSET + k;
			if (b % 2 == 1)
				dl_words[b / 2][15:8] = serial[63 - 8 * k -: 8];
			else
				dl_words[b / 2][7:0] = serial[63 - 8 * k -: 8];
		end
	endtask

	task automatic download_image(input int words, input bit with_serial,
			input logic [63:0] serial, input int hold);
		for (int i = 0; i < words; i++)
			dl_words[i] = 16'($urandom);
		if (with_serial)
			place_serial(serial);
		mask_ref = '0;
		cart_dl  = 1'b1;
		next_cycle();
		for (int i = 0; i < words; i++) begin
			cart_dl_wr   = 1'b1;
			cart_dl_addr = 25'(2 * i);
			cart_dl_data = dl_words[i];
			mask_ref     = mask_ref | ROM_AW'(i);
			rom_ref[i]   = dl_words[i];
			next_cycle();
		end
		cart_dl_wr = 1'b0;
		size_ref   = words;
		repeat (hold) next_cycle();
		cart_dl = 1'b0;
		next_cycle();
	endtask

	task automatic read_cart(input logic [22:0] addr, input bit cs, input bit check_data,
			input logic [15:0] exp_word, input bit exp_en);
		cart_addr = addr;
		cart_cs   = cs;
		cart_oe   = 1'b1;
		due_q.push_back(cycle_count + 2);
		exp_q.push_back(exp_word);
		en_q.push_back(exp_en);
		data_q.push_back(check_data);
		repeat (2) next_cycle();
		cart_oe = 1'b0;
		cart_cs = 1'b0;
	endtask

	task automatic read_rom(input logic [22:0] addr);
		read_cart(addr, 1'b1, 1'b1, expected_rom_word(addr), 1'b1);
	endtask

	// Registers 1 to 7 only move once the image spans more than eight pages
	task automatic write_bank(input int idx, input int page);
		cart_addr    = 23'(idx);
		cart_data_wr = 16'(page);
		cart_time    = 1'b1;
		cart_lwr     = 1'b1;
		next_cycle();
		cart_time = 1'b0;
		cart_lwr  = 1'b0;
		if (idx != 0 && int'(mask_ref) >= 2**(PAGE_AW + 3)) begin
			bank_ref[idx] = 4'(page);
			bank_on_ref   = 1'b1;
		end
	endtask

	task automatic write_save(input logic [22:0] addr, input logic [7:0] val,
			input bit exp_change);
		cart_addr    = addr;
		cart_data_wr = {8'h00, val};
		cart_lwr     = 1'b1;
		@(negedge clk);
		checks++;
		assert (save_change === exp_change) else begin
			errors++;
			$display("FAIL t=%0t save_change exp=%b got=%b", $time, exp_change, save_change);
		end
		next_cycle();
		cart_lwr = 1'b0;
	endtask

	task automatic read_host(input logic [13:0] word, input logic [15:0] keep,
			input logic [15:0] exp_word);
		save_addr = word;
		repeat (2) next_cycle();
		checks++;
		assert ((save_do & keep) === (exp_word & keep)) else begin
			errors++;
			$display("FAIL t=%0t save_do exp=%h got=%h", $time, exp_word & keep, save_do & keep);
		end
	endtask

	task automatic drain_checks();
		int waited;
		waited = 0;
		while (due_q.size() > 0 && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited++;
		end
		assert (due_q.size() == 0) else begin
			errors++;
			$display("Timeout: read checks still pending after %0d cycles", DRAIN_LIMIT);
		end
	endtask

	//==========================================================================
	// Stimulus
	//==========================================================================
	initial begin : stimulus
		logic [22:0] addr;
		logic [22:0] off;
		logic [7:0]  val;
		void'($urandom(SEED));
		reset        = 1'b1;
		cart_dl      = 1'b0;
		cart_dl_wr   = 1'b0;
		cart_dl_addr = '0;
		cart_dl_data = '0;
		cart_addr    = '0;
		cart_cs      = 1'b0;
		cart_oe      = 1'b0;
		cart_lwr     = 1'b0;
		cart_uwr     = 1'b0;
		cart_time    = 1'b0;
		cart_data_wr = '0;
		save_addr    = '0;
		save_di      = '0;
		save_wr      = 1'b0;
		size_ref     = 0;
		mask_ref     = '0;
		bank_on_ref  = 1'b0;
		for (int n = 0; n < 8; n++)
			bank_ref[n] = 4'(n);
		pulse_reset();

		// Plain image and linear reads with high address bits set
		download_image(144, 1'b0, '0, 4);
		for (int n = 0; n < 24; n++) begin
			addr = {3'b000, 12'($urandom), 8'($urandom % size_ref)};
			read_rom(addr);
		end

		// Page 1 moved to page 6 and then every bank remapped
		write_bank(1, 6);
		for (int n = 0; n < 8; n++) begin
			addr = {3'b000, 12'($urandom), 1'b0, 3'd1, 4'($urandom)};
			read_rom(addr);
		end
		for (int n = 1; n < 8; n++)
			write_bank(n, $urandom % 9);
		for (int n = 0; n < 16; n++) begin
			addr = {3'b000, 12'($urandom), 8'($urandom)};
			read_rom(addr);
		end
		drain_checks();

		// Reset brings back the linear mapping
		pulse_reset();
		for (int n = 0; n < 8; n++)
			bank_ref[n] = 4'(n);
		bank_on_ref = 1'b0;
		for (int n = 0; n < 8; n++) begin
			addr = {3'b000, 12'($urandom), 8'($urandom % size_ref)};
			read_rom(addr);
		end

		// Save RAM past the end of the image through CPU and host ports
		for (int n = 0; n < 4; n++) begin
			off = 23'($urandom) & 23'h7fff;
			val = 8'($urandom);
			write_save(SAVE_BASE | off, val, 1'b1);
			read_cart(SAVE_BASE | off, 1'b0, 1'b1, {val, val}, 1'b1);
			read_host(off[14:1], off[0] ? 16'hff00 : 16'h00ff, {val, val});
		end

		// Image that must not see save RAM
		download_image(208, 1'b1, cart_id_pkg::NORAM_SERIAL, 4);
		for (int n = 0; n < 4; n++) begin
			off = 23'($urandom) & 23'h7fff;
			write_save(SAVE_BASE | off, 8'($urandom), 1'b0);
			read_cart(SAVE_BASE | off, 1'b0, 1'b0, 16'h0000, 1'b0);
			read_rom(23'($urandom % size_ref));
		end

		// Fill value follows the quirk of the loading image
		download_image(208, 1'b1, cart_id_pkg::SRAM00_SERIAL, FILL_CYCLES);
		for (int n = 0; n < 4; n++)
			read_host(14'($urandom), 16'hffff, 16'h0000);
		download_image(144, 1'b0, '0, FILL_CYCLES);
		for (int n = 0; n < 4; n++)
			read_host(14'($urandom), 16'hffff, 16'hffff);

		drain_checks();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
